/* Bender.yml */
package:
  name: smc

sources:
  - source/smc_pkg.sv
  - source/mosfet_model.sv
  - source/device_stage.sv
  - source/sort_network.sv
  - source/rank_average.sv
  - source/smc.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/smc_tb.sv

/* smc.f */
+incdir+tb
source/smc_pkg.sv
source/mosfet_model.sv
source/device_stage.sv
source/sort_network.sv
source/rank_average.sv
source/smc.sv
tb/smc_tb.sv

/* source/device_stage.sv */
`timescale 1ns/1ps

module device_stage (
  input  logic               clk,
  input  logic               rst,
  input  smc_pkg::volt_t     vgs [smc_pkg::CHANNELS],
  input  smc_pkg::volt_t     vds [smc_pkg::CHANNELS],
  input  smc_pkg::volt_t     w   [smc_pkg::CHANNELS],
  input  smc_pkg::calc_sel_e calc_sel,
  input  smc_pkg::rank_sel_e rank_sel,
  output smc_pkg::prod_vec_t prod_q,
  output smc_pkg::calc_sel_e calc_sel_q,
  output smc_pkg::rank_sel_e rank_sel_q
);

  smc_pkg::prod_vec_t prod_d;

  // ==================================================
  // per-channel evaluation
  // ==================================================

  for (genvar ch = 0; ch < smc_pkg::CHANNELS; ch++) begin : g_channel
    mosfet_model u_mosfet (
      .vgs      (vgs[ch]),
      .vds      (vds[ch]),
      .w        (w[ch]),
      .calc_sel (calc_sel),
      .prod     (prod_d[ch])
    );
  end

  // ==================================================
  // first pipeline register
  // ==================================================

  // mode travels with its products so both stay aligned
  always_ff @(posedge clk) begin
    if (rst) begin
      prod_q     <= '0;
      calc_sel_q <= smc_pkg::SEL_GM;
      rank_sel_q <= smc_pkg::SEL_MIN;
    end else begin
      prod_q     <= prod_d;
      calc_sel_q <= calc_sel;
      rank_sel_q <= rank_sel;
    end
  end

endmodule

/* source/mosfet_model.sv */
`timescale 1ns/1ps

module mosfet_model (
  input  smc_pkg::volt_t     vgs,
  input  smc_pkg::volt_t     vds,
  input  smc_pkg::volt_t     w,
  input  smc_pkg::calc_sel_e calc_sel,
  output smc_pkg::prod_t     prod
);

  smc_pkg::volt_t overdrive;
  logic           triode;

  // operands widened to the current width
  smc_pkg::curr_t od_ext;
  smc_pkg::curr_t vds_ext;

  smc_pkg::curr_t id_val;
  smc_pkg::curr_t gm_val;
  smc_pkg::curr_t sel_val;

  // threshold of one volt
  assign overdrive = vgs - smc_pkg::volt_t'(1);

  // equal overdrive and vds counts as saturation
  assign triode = overdrive > vds;

  assign od_ext  = smc_pkg::curr_t'(overdrive);
  assign vds_ext = smc_pkg::curr_t'(vds);

  always_comb begin
    if (triode) begin
      // 2*od*vds - vds^2, at most 35
      id_val = ((od_ext << 1) * vds_ext) - (vds_ext * vds_ext);
      gm_val = vds_ext << 1;
    end else begin
      id_val = od_ext * od_ext;
      gm_val = od_ext << 1;
    end
  end

  assign sel_val = (calc_sel == smc_pkg::SEL_ID) ? id_val : gm_val;

  // scale by transistor width
  assign prod = smc_pkg::prod_t'(sel_val) * smc_pkg::prod_t'(w);

endmodule

/* source/rank_average.sv */
`timescale 1ns/1ps

module rank_average (
  input  logic               clk,
  input  logic               rst,
  input  smc_pkg::prod_vec_t sorted,
  input  smc_pkg::calc_sel_e calc_sel,
  input  smc_pkg::rank_sel_e rank_sel,
  output smc_pkg::prod_t     out_n
);

  // picked values and their thirds, in sorted order
  smc_pkg::prod_t pick [smc_pkg::PICK];
  smc_pkg::prod_t frac [smc_pkg::PICK];

  smc_pkg::prod_t gm_sum;
  smc_pkg::prod_t result;

  logic [smc_pkg::SUM_W-1:0] fw0;
  logic [smc_pkg::SUM_W-1:0] fw1;
  logic [smc_pkg::SUM_W-1:0] fw2;
  logic [smc_pkg::SUM_W-1:0] wsum;
  logic [smc_pkg::SUM_W-1:0] wsum_q4;

  // ==================================================
  // selection and division by three
  // ==================================================

  always_comb begin
    for (int i = 0; i < smc_pkg::PICK; i++) begin
      // top three or bottom three of the sorted set
      pick[i] = (rank_sel == smc_pkg::SEL_MAX) ? sorted[i] : sorted[i + smc_pkg::PICK];
      frac[i] = smc_pkg::prod_t'(pick[i] / smc_pkg::PICK);
    end
  end

  // ==================================================
  // averaging
  // ==================================================

  // thirds are at most 84, so this sum fits 8 bits
  assign gm_sum = frac[0] + frac[1] + frac[2];

  assign fw0 = smc_pkg::SUM_W'(frac[0]);
  assign fw1 = smc_pkg::SUM_W'(frac[1]);
  assign fw2 = smc_pkg::SUM_W'(frac[2]);

  // weights 3, 4, 5 built from shifts
  assign wsum    = ((fw0 << 1) + fw0) + (fw1 << 2) + ((fw2 << 2) + fw2);
  assign wsum_q4 = wsum >> 2;

  assign result = (calc_sel == smc_pkg::SEL_ID)
                ? smc_pkg::prod_t'(wsum_q4 / smc_pkg::PICK)
                : smc_pkg::prod_t'(gm_sum / smc_pkg::PICK);

  // output register
  always_ff @(posedge clk) begin
    if (rst) begin
      out_n <= '0;
    end else begin
      out_n <= result;
    end
  end

endmodule

/* source/smc.sv */
`timescale 1ns/1ps

module smc (
  input  logic       clk,
  input  logic       rst,
  input  logic [1:0] mode,
  input  logic [2:0] w_0,
  input  logic [2:0] v_gs_0,
  input  logic [2:0] v_ds_0,
  input  logic [2:0] w_1,
  input  logic [2:0] v_gs_1,
  input  logic [2:0] v_ds_1,
  input  logic [2:0] w_2,
  input  logic [2:0] v_gs_2,
  input  logic [2:0] v_ds_2,
  input  logic [2:0] w_3,
  input  logic [2:0] v_gs_3,
  input  logic [2:0] v_ds_3,
  input  logic [2:0] w_4,
  input  logic [2:0] v_gs_4,
  input  logic [2:0] v_ds_4,
  input  logic [2:0] w_5,
  input  logic [2:0] v_gs_5,
  input  logic [2:0] v_ds_5,
  output logic [7:0] out_n
);

  smc_pkg::volt_t     vgs_arr [smc_pkg::CHANNELS];
  smc_pkg::volt_t     vds_arr [smc_pkg::CHANNELS];
  smc_pkg::volt_t     w_arr   [smc_pkg::CHANNELS];
  smc_pkg::calc_sel_e calc_sel;
  smc_pkg::rank_sel_e rank_sel;

  smc_pkg::prod_vec_t prod_q;
  smc_pkg::calc_sel_e calc_sel_q;
  smc_pkg::rank_sel_e rank_sel_q;
  smc_pkg::prod_vec_t sorted;

  // ==================================================
  // input packing
  // ==================================================

  assign vgs_arr = '{v_gs_0, v_gs_1, v_gs_2, v_gs_3, v_gs_4, v_gs_5};
  assign vds_arr = '{v_ds_0, v_ds_1, v_ds_2, v_ds_3, v_ds_4, v_ds_5};
  assign w_arr   = '{w_0, w_1, w_2, w_3, w_4, w_5};

  // bit 0 picks Id or gm, bit 1 picks max or min
  assign calc_sel = smc_pkg::calc_sel_e'(mode[0]);
  assign rank_sel = smc_pkg::rank_sel_e'(mode[1]);

  // ==================================================
  // pipeline
  // ==================================================

  device_stage u_device (
    .clk        (clk),
    .rst        (rst),
    .vgs        (vgs_arr),
    .vds        (vds_arr),
    .w          (w_arr),
    .calc_sel   (calc_sel),
    .rank_sel   (rank_sel),
    .prod_q     (prod_q),
    .calc_sel_q (calc_sel_q),
    .rank_sel_q (rank_sel_q)
  );

  // combinational, between the two registers
  sort_network u_sort (
    .values (prod_q),
    .sorted (sorted)
  );

  rank_average u_avg (
    .clk      (clk),
    .rst      (rst),
    .sorted   (sorted),
    .calc_sel (calc_sel_q),
    .rank_sel (rank_sel_q),
    .out_n    (out_n)
  );

endmodule

/* source/smc_pkg.sv */
package smc_pkg;

  // ==================================================
  // channel geometry
  // ==================================================

  // six transistors evaluated in parallel
  localparam int CHANNELS = 6;

  // gate, drain and width inputs are all 3 bits
  localparam int VOLT_W = 3;
  typedef logic [VOLT_W-1:0] volt_t;

  // drain current or transconductance, up to 36
  localparam int CURR_W = 6;
  typedef logic [CURR_W-1:0] curr_t;

  // ==================================================
  // datapath values
  // ==================================================

  // width-scaled value, 36 * 7 stays below 256
  localparam int PROD_W = 8;
  typedef logic [PROD_W-1:0] prod_t;
  typedef prod_t [CHANNELS-1:0] prod_vec_t;

  // weighted sum 3*f0 + 4*f1 + 5*f2 reaches 1008
  localparam int SUM_W = 10;

  // three picked values, also the divisor
  localparam int PICK = 3;

  // mode bit 0
  typedef enum logic {
    SEL_GM = 1'b0,
    SEL_ID = 1'b1
  } calc_sel_e;

  // mode bit 1
  typedef enum logic {
    SEL_MIN = 1'b0,
    SEL_MAX = 1'b1
  } rank_sel_e;

endpackage

/* source/sort_network.sv */
`timescale 1ns/1ps

module sort_network (
  input  smc_pkg::prod_vec_t values,
  output smc_pkg::prod_vec_t sorted
);

  // outputs of each compare-exchange layer
  smc_pkg::prod_vec_t layer_1;
  smc_pkg::prod_vec_t layer_2;
  smc_pkg::prod_vec_t layer_3;
  smc_pkg::prod_vec_t layer_4;
  smc_pkg::prod_vec_t layer_5;

  // larger value moves to the lower index
  function automatic smc_pkg::prod_vec_t cmp_xchg(
    input smc_pkg::prod_vec_t v,
    input int unsigned        hi,
    input int unsigned        lo
  );
    smc_pkg::prod_vec_t r;
    r = v;
    if (v[lo] > v[hi]) begin
      r[hi] = v[lo];
      r[lo] = v[hi];
    end
    return r;
  endfunction

  // ==================================================
  // five layers, descending order
  // ==================================================

  always_comb begin
    // layer 1: (0,5) (1,3) (2,4)
    layer_1 = cmp_xchg(values, 0, 5);
    layer_1 = cmp_xchg(layer_1, 1, 3);
    layer_1 = cmp_xchg(layer_1, 2, 4);

    // layer 2: (1,2) (3,4)
    layer_2 = cmp_xchg(layer_1, 1, 2);
    layer_2 = cmp_xchg(layer_2, 3, 4);

    // layer 3: (0,3) (2,5)
    layer_3 = cmp_xchg(layer_2, 0, 3);
    layer_3 = cmp_xchg(layer_3, 2, 5);

    // layer 4: (0,1) (2,3) (4,5)
    layer_4 = cmp_xchg(layer_3, 0, 1);
    layer_4 = cmp_xchg(layer_4, 2, 3);
    layer_4 = cmp_xchg(layer_4, 4, 5);

    // layer 5: (1,2) (3,4)
    layer_5 = cmp_xchg(layer_4, 1, 2);
    layer_5 = cmp_xchg(layer_5, 3, 4);
  end

  // index 0 holds the largest product
  assign sorted = layer_5;

endmodule

/* tb/smc_model.svh */
`ifndef SMC_MODEL_SVH
`define SMC_MODEL_SVH

// width-scaled current or transconductance of one transistor
function automatic int channel_value(
  input int vgs,
  input int vds,
  input int w,
  input bit use_id
);
  int od;
  int val;
  od = vgs - 1;
  if (od > vds) begin
    // triode region
    val = use_id ? (2 * od * vds - vds * vds) : (2 * vds);
  end else begin
    val = use_id ? (od * od) : (2 * od);
  end
  return val * w;
endfunction

// insertion sort, largest first
function automatic void sort_descending(
  input  int vals   [smc_pkg::CHANNELS],
  output int sorted [smc_pkg::CHANNELS]
);
  int tmp;
  sorted = vals;
  for (int i = 1; i < smc_pkg::CHANNELS; i++) begin
    for (int j = i; j > 0 && sorted[j] > sorted[j-1]; j--) begin
      tmp = sorted[j];
      sorted[j] = sorted[j-1];
      sorted[j-1] = tmp;
    end
  end
endfunction

// thirds of the three picked values, then the mode's average
function automatic int average_picked(
  input int sorted [smc_pkg::CHANNELS],
  input bit use_max,
  input bit use_id
);
  int f [3];
  int base;
  base = use_max ? 0 : 3;
  for (int i = 0; i < 3; i++) begin
    f[i] = sorted[base + i] / 3;
  end
  if (use_id) begin
    return ((3 * f[0] + 4 * f[1] + 5 * f[2]) / 4) / 3;
  end
  return (f[0] + f[1] + f[2]) / 3;
endfunction

// full result for one input set
function automatic int expected_out(
  input int vgs [smc_pkg::CHANNELS],
  input int vds [smc_pkg::CHANNELS],
  input int w   [smc_pkg::CHANNELS],
  input bit use_id,
  input bit use_max
);
  int vals   [smc_pkg::CHANNELS];
  int sorted [smc_pkg::CHANNELS];
  for (int ch = 0; ch < smc_pkg::CHANNELS; ch++) begin
    vals[ch] = channel_value(vgs[ch], vds[ch], w[ch], use_id);
  end
  sort_descending(vals, sorted);
  return average_picked(sorted, use_max, use_id);
endfunction

`endif

/* tb/smc_tb.sv */
`timescale 1ns/1ps

module smc_tb;

  localparam logic [31:0] SEED         = 32'h34cc34bd;
  localparam int          CLK_PERIOD   = 100;
  localparam int          RESET_CYCLES = 8;
  localparam int          NUM_RANDOM   = 60;
  localparam int          NUM_STREAM   = 400;
  localparam int          EDGE_LIMIT   = 2 * CLK_PERIOD;
  localparam real         POLL_STEP    = 1.0;
  localparam real         POLL_OFFSET  = 0.5;

  logic       clk;
  logic       rst;
  logic [1:0] mode;
  logic [2:0] vgs_in [smc_pkg::CHANNELS];
  logic [2:0] vds_in [smc_pkg::CHANNELS];
  logic [2:0] w_in   [smc_pkg::CHANNELS];
  logic [7:0] out_n;

  // input set being prepared
  int set_vgs [smc_pkg::CHANNELS];
  int set_vds [smc_pkg::CHANNELS];
  int set_w   [smc_pkg::CHANNELS];

  // results in flight in arrival order
  int    exp_q  [$];
  string name_q [$];

  int checks;
  int errors;
  int timeouts;

  `include "smc_model.svh"

  smc UUT (
    .clk    (clk),
    .rst    (rst),
    .mode   (mode),
    .w_0 (w_in[0]), .v_gs_0 (vgs_in[0]), .v_ds_0 (vds_in[0]),
    .w_1 (w_in[1]), .v_gs_1 (vgs_in[1]), .v_ds_1 (vds_in[1]),
    .w_2 (w_in[2]), .v_gs_2 (vgs_in[2]), .v_ds_2 (vds_in[2]),
    .w_3 (w_in[3]), .v_gs_3 (vgs_in[3]), .v_ds_3 (vds_in[3]),
    .w_4 (w_in[4]), .v_gs_4 (vgs_in[4]), .v_ds_4 (vds_in[4]),
    .w_5 (w_in[5]), .v_gs_5 (vgs_in[5]), .v_ds_5 (vds_in[5]),
    .out_n  (out_n)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  // ==================================================
  // helpers
  // ==================================================

  task automatic finish_run();
    $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  endtask

  // poll off the clock edges through the high phase and then the drop
  task automatic wait_fall();
    int rise_polls;
    int fall_polls;
    rise_polls = 0;
    fall_polls = 0;
    while (clk !== 1'b1 && rise_polls < EDGE_LIMIT) begin
      #(POLL_STEP);
      rise_polls++;
    end
    while (clk !== 1'b0 && fall_polls < EDGE_LIMIT) begin
      #(POLL_STEP);
      fall_polls++;
    end
    if (rise_polls >= EDGE_LIMIT || fall_polls >= EDGE_LIMIT) begin
      timeouts++;
      $display("Timeout: the clock did not fall within %0d ns", 2 * EDGE_LIMIT);
      finish_run();
    end
  endtask

  task automatic check_value(input string name, input int exp);
    checks++;
    assert (out_n === 8'(exp)) else begin
      errors++;
      $display("Error: %s expected %0d actual %0d", name, exp, out_n);
    end
  endtask

  task automatic drive_set(input logic [1:0] mode_v);
    for (int ch = 0; ch < smc_pkg::CHANNELS; ch++) begin
      vgs_in[ch] = 3'(set_vgs[ch]);
      vds_in[ch] = 3'(set_vds[ch]);
      w_in[ch]   = 3'(set_w[ch]);
    end
    mode = mode_v;
  endtask

  // legal range 1 to 7
  task automatic random_set();
    for (int ch = 0; ch < smc_pkg::CHANNELS; ch++) begin
      set_vgs[ch] = 1 + $urandom_range(6);
      set_vds[ch] = 1 + $urandom_range(6);
      set_w[ch]   = 1 + $urandom_range(6);
    end
  endtask

  // zero overdrive so every channel gives 0
  task automatic idle_set();
    for (int ch = 0; ch < smc_pkg::CHANNELS; ch++) begin
      set_vgs[ch] = 1;
      set_vds[ch] = 1;
      set_w[ch]   = 1;
    end
  endtask

  // shift 0 puts overdrive equal to vds and shift 1 one step into triode
  task automatic boundary_set(input int shift);
    for (int ch = 0; ch < smc_pkg::CHANNELS; ch++) begin
      set_vds[ch] = (ch % 5) + 1;
      set_vgs[ch] = set_vds[ch] + 1 + shift;
      set_w[ch]   = 7 - ch;
    end
  endtask

  // products of 252 and 216
  task automatic large_set();
    for (int ch = 0; ch < smc_pkg::CHANNELS; ch++) begin
      set_vgs[ch] = 7;
      set_vds[ch] = 6 + (ch % 2);
      set_w[ch]   = (ch < 4) ? 7 : 6;
    end
  endtask

  // check the set from two falling edges ago and then apply the next one
  task automatic step(input string name, input logic [1:0] mode_v);
    wait_fall();
    if (exp_q.size() == 2) begin
      check_value(name_q.pop_front(), exp_q.pop_front());
    end
    drive_set(mode_v);
    exp_q.push_back(expected_out(set_vgs, set_vds, set_w, mode_v[0], mode_v[1]));
    name_q.push_back(name);
  endtask

  task automatic apply_reset(input int cycles, input string name);
    exp_q.delete();
    name_q.delete();
    // random traffic keeps running while rst is high
    rst = 1'b1;
    random_set();
    drive_set(2'($urandom_range(3)));
    for (int i = 0; i < cycles; i++) begin
      wait_fall();
      check_value(name, 0);
      if (i < cycles - 1) begin
        random_set();
        drive_set(2'($urandom_range(3)));
      end
    end
    rst = 1'b0;
    idle_set();
    drive_set(2'b00);
    // cleared registers and then the idle set
    exp_q.push_back(0);
    name_q.push_back(name);
    exp_q.push_back(0);
    name_q.push_back(name);
  endtask

  task automatic drain();
    while (exp_q.size() > 0) begin
      wait_fall();
      check_value(name_q.pop_front(), exp_q.pop_front());
    end
  endtask

  // ==================================================
  // test sequence
  // ==================================================

  initial begin
    logic [1:0] m;
    checks   = 0;
    errors   = 0;
    timeouts = 0;
    void'($urandom(SEED));
    rst = 1'b1;
    idle_set();
    drive_set(2'b00);
    #(POLL_OFFSET);

    apply_reset(RESET_CYCLES, "reset");

    for (int i = 0; i < NUM_RANDOM; i++) begin
      random_set();
      m = {1'($urandom_range(1)), 1'b0};
      step("gm_random", m);
    end

    for (int i = 0; i < NUM_RANDOM; i++) begin
      random_set();
      m = {1'($urandom_range(1)), 1'b1};
      step("id_random", m);
    end

    large_set();
    step("id_large", 2'b11);
    step("id_large", 2'b01);

    // region boundary in all four modes
    for (int shift = 0; shift < 2; shift++) begin
      for (int mv = 0; mv < 4; mv++) begin
        boundary_set(shift);
        step("boundary", 2'(mv));
      end
    end

    for (int i = 0; i < NUM_STREAM; i++) begin
      random_set();
      step("back_to_back", 2'($urandom_range(3)));
    end

    apply_reset(3, "mid_reset");

    for (int i = 0; i < NUM_RANDOM; i++) begin
      random_set();
      step("after_reset", 2'($urandom_range(3)));
    end

    drain();
    finish_run();
  end

endmodule
